// File: sim.f
+incdir+hdl
hdl/memreq_pkg.sv
hdl/cmd_parser.sv
hdl/axi_write_port.sv
hdl/axi_read_port.sv
hdl/resp_encoder.sv
hdl/memreq_top.sv
bench/memreq_props.sv
bench/memreq_tb.sv

// File: Makefile
# Verilator build and run of the memreq testbench

TOP := memreq_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module $(TOP) -f sim.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/memreq_tb.sv
`timescale 1ns/10ps
module memreq_tb;

  localparam int NUM_ENTRIES = 10;

  typedef struct packed {
    logic [7:0]             cmd;
    memreq_pkg::mem_addr_t  addr;
    memreq_pkg::burst_len_t len;
    memreq_pkg::txn_id_t    id;
    logic                   err;   // Model answers with SLVERR
    logic [31:0]            seed;  // Start of the store data sequence
  } entry_t;

  logic bus_clock, bus_reset;
  logic s_tvalid_i, s_tready_o, s_tlast_i;
  logic [7:0] s_tdata_i;
  logic m_tvalid_o, m_tready_i, m_tlast_o;
  logic [7:0] m_tdata_o;
  logic awvalid_o, awready_i, wvalid_o, wready_i, wlast_o, bvalid_i, bready_o;
  memreq_pkg::mem_addr_t awaddr_o, araddr_o;
  memreq_pkg::txn_id_t awid_o, bid_i, arid_o, rid_i;
  memreq_pkg::burst_len_t awlen_o, arlen_o;
  logic [1:0] awburst_o, arburst_o;
  logic [3:0] wstrb_o;
  memreq_pkg::mem_word_t wdata_o, rdata_i;
  memreq_pkg::axi_resp_t bresp_i, rresp_i;
  logic arvalid_o, arready_i, rvalid_i, rready_o, rlast_i;

  entry_t tbl [NUM_ENTRIES];
  int cur;
  int errors;
  int rx_frames;
  logic [31:0] rng_state = 32'd41;
  memreq_pkg::mem_word_t exp_words [256];  // Store data of the current entry
  memreq_pkg::mem_word_t axi_mem [memreq_pkg::mem_addr_t];
  memreq_pkg::mem_word_t ref_mem [memreq_pkg::mem_addr_t];  // Expected memory contents
  logic [7:0] rx_bytes [$];
  logic rx_lasts [$];

  memreq_top dut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic next_ready();
    rng_state = xorshift32(rng_state);
    return rng_state[4:3] != 2'b00;  // Ready three cycles in four
  endfunction

  // Unwritten locations read back a value tied to the full address
  function automatic memreq_pkg::mem_word_t fill_word(input memreq_pkg::mem_addr_t a);
    return {a, 4'h9};
  endfunction

  function automatic memreq_pkg::mem_word_t model_word(input memreq_pkg::mem_addr_t a);
    return axi_mem.exists(a) ? axi_mem[a] : fill_word(a);
  endfunction

  function automatic memreq_pkg::mem_word_t ref_word(input memreq_pkg::mem_addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  task automatic check_code(input string name, input memreq_pkg::cmd_e got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input memreq_pkg::txn_id_t got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input memreq_pkg::mem_addr_t got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input memreq_pkg::mem_word_t got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_len(input string name, input memreq_pkg::burst_len_t got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Small fields and flags
  task automatic check_bits(input string name, input logic [7:0] got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic send_byte(input logic [7:0] b, input logic last);
    s_tvalid_i = 1'b1;
    s_tdata_i  = b;
    s_tlast_i  = last;
    @(posedge bus_clock);
    while (!s_tready_o) @(posedge bus_clock);
    #1;
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
  endtask

  task automatic send_frame(input entry_t e, input int n_words);
    logic is_store;
    is_store = e.cmd == 8'h01;
    send_byte(e.cmd, 1'b0);
    send_byte(e.len, 1'b0);
    send_byte(e.addr[7:0], 1'b0);
    send_byte(e.addr[15:8], 1'b0);
    send_byte(e.addr[23:16], 1'b0);
    send_byte({e.id, e.addr[27:24]}, !is_store);
    if (is_store) begin
      for (int k = 0; k < n_words; k++) begin
        for (int j = 0; j < 4; j++) begin
          send_byte(exp_words[k][8*j +: 8], k == n_words - 1 && j == 3);
        end
      end
    end
  endtask

  task automatic check_response(input entry_t e, input int n_words);
    logic [7:0] b;
    logic last;
    logic is_store;
    memreq_pkg::mem_word_t w;
    memreq_pkg::cmd_e exp_code;
    int n_bytes;
    is_store = e.cmd == 8'h01;
    n_bytes  = is_store ? 2 : 2 + 4 * n_words;
    if (is_store) exp_code = e.err ? memreq_pkg::CMD_WFAIL : memreq_pkg::CMD_WDONE;
    else exp_code = e.err ? memreq_pkg::CMD_RFAIL : memreq_pkg::CMD_RDATA;
    if (rx_bytes.size() < n_bytes) begin
      $display("Response for id %0d has %0d bytes, %0d expected", e.id, rx_bytes.size(), n_bytes);
      errors++;
      rx_bytes.delete();
      rx_lasts.delete();
      return;
    end
    b    = rx_bytes.pop_front();
    last = rx_lasts.pop_front();
    check_code("m_tdata_o code", memreq_pkg::cmd_e'(b), exp_code);
    check_bits("m_tlast_o", 8'(last), 8'h00);
    b    = rx_bytes.pop_front();
    last = rx_lasts.pop_front();
    check_bits("m_tdata_o id", b, {4'h0, e.id});
    check_bits("m_tlast_o", 8'(last), 8'(is_store));
    if (!is_store) begin
      for (int k = 0; k < n_words; k++) begin
        w = '0;
        for (int j = 0; j < 4; j++) begin
          w[8*j +: 8] = rx_bytes.pop_front();
          last = rx_lasts.pop_front();
          check_bits("m_tlast_o", 8'(last), 8'(k == n_words - 1 && j == 3));
        end
        check_word("m_tdata_o word", w, ref_word(e.addr + 28'(4 * k)));
      end
    end
    if (rx_bytes.size() != 0) begin
      $display("Response for id %0d carries %0d extra bytes", e.id, rx_bytes.size());
      errors++;
      rx_bytes.delete();
      rx_lasts.delete();
    end
  endtask

  initial begin
    bus_clock = 1'b0;
    forever #2 bus_clock = ~bus_clock;
  end

  initial begin
    #(NUM_ENTRIES * 2000);
    $display("Timeout: run did not finish within %0d ns", NUM_ENTRIES * 2000);
    $display("TEST FAILED");
    $finish;
  end

  // Response stream sink
  initial begin
    rx_frames = 0;
    forever begin
      @(posedge bus_clock);
      if (m_tvalid_o && m_tready_i) begin
        rx_bytes.push_back(m_tdata_o);
        rx_lasts.push_back(m_tlast_o);
        if (m_tlast_o) rx_frames++;
      end
    end
  end

  // AXI memory model that answers SLVERR when address bit 27 is set
  initial begin : axi_slave
    memreq_pkg::mem_addr_t wr_addr, rd_addr;
    memreq_pkg::txn_id_t wr_id, rd_id;
    int wr_beat, rd_beat, rd_left;
    logic b_pend;
    {awready_i, wready_i, bvalid_i, arready_i, rvalid_i, rlast_i} = '0;
    m_tready_i = 1'b0;
    bresp_i = '0;
    bid_i   = '0;
    rresp_i = '0;
    rid_i   = '0;
    rdata_i = '0;
    wr_addr = '0;
    rd_addr = '0;
    wr_id   = '0;
    rd_id   = '0;
    wr_beat = 0;
    rd_beat = 0;
    rd_left = 0;
    b_pend  = 1'b0;
    forever begin
      @(posedge bus_clock);
      if (awvalid_o && awready_i) begin
        if (tbl[cur].cmd != 8'h01) begin
          $display("AW handshake seen for a frame that is not a store");
          errors++;
        end
        check_addr("awaddr_o", awaddr_o, tbl[cur].addr);
        check_id("awid_o", awid_o, tbl[cur].id);
        check_len("awlen_o", awlen_o, tbl[cur].len);
        check_bits("awburst_o", 8'(awburst_o), 8'h01);
        wr_addr = awaddr_o;
        wr_id   = awid_o;
        wr_beat = 0;
      end
      if (wvalid_o && wready_i) begin
        check_bits("wstrb_o", 8'(wstrb_o), 8'h0f);
        check_word("wdata_o", wdata_o, exp_words[wr_beat % 256]);
        check_bits("wlast_o", 8'(wlast_o), 8'(wr_beat == int'(tbl[cur].len)));
        if (!wr_addr[27]) axi_mem[wr_addr + 28'(4 * wr_beat)] = wdata_o;
        if (wlast_o) b_pend = 1'b1;
        wr_beat++;
      end
      if (bvalid_i && bready_o) b_pend = 1'b0;
      if (arvalid_o && arready_i) begin
        if (tbl[cur].cmd != 8'h80) begin
          $display("AR handshake seen for a frame that is not a fetch");
          errors++;
        end
        check_addr("araddr_o", araddr_o, tbl[cur].addr);
        check_id("arid_o", arid_o, tbl[cur].id);
        check_len("arlen_o", arlen_o, tbl[cur].len);
        check_bits("arburst_o", 8'(arburst_o), 8'h01);
        rd_addr = araddr_o;
        rd_id   = arid_o;
        rd_left = int'(arlen_o) + 1;
        rd_beat = 0;
      end
      if (rvalid_i && rready_o) begin
        rd_left--;
        rd_beat++;
      end
      #1;
      m_tready_i = next_ready();  // Response back-pressure
      awready_i  = next_ready();
      wready_i   = next_ready();
      arready_i  = next_ready();
      bvalid_i   = b_pend;
      bresp_i    = wr_addr[27] ? 2'b10 : 2'b00;
      bid_i      = wr_id;
      rvalid_i   = rd_left > 0;
      rlast_i    = rd_left == 1;
      rresp_i    = rd_addr[27] ? 2'b10 : 2'b00;
      rid_i      = rd_id;
      rdata_i    = model_word(rd_addr + 28'(4 * rd_beat));
    end
  end

  initial begin : main
    int n_words;
    int seen;
    logic [31:0] s;
    errors     = 0;
    cur        = 0;
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    s_tdata_i  = '0;
    bus_reset  = 1'b1;
    // cmd, address, length, id, error, data seed
    tbl[0] = '{8'h01, 28'h000_0100, 8'd3, 4'h1, 1'b0, 32'h1234_5678};
    tbl[1] = '{8'h80, 28'h000_0100, 8'd3, 4'h2, 1'b0, 32'h0000_0001};
    tbl[2] = '{8'h01, 28'h0AB_CDE0, 8'd0, 4'h3, 1'b0, 32'h9E37_79B9};
    tbl[3] = '{8'h01, 28'h800_0040, 8'd1, 4'h4, 1'b1, 32'h0BAD_F00D};
    tbl[4] = '{8'h55, 28'h000_0200, 8'd0, 4'h0, 1'b0, 32'h0000_0001};  // Unknown command
    tbl[5] = '{8'h80, 28'h0AB_CDE0, 8'd0, 4'h5, 1'b0, 32'h0000_0001};
    tbl[6] = '{8'h80, 28'h800_0040, 8'd1, 4'h6, 1'b1, 32'h0000_0001};
    tbl[7] = '{8'h01, 28'h001_2340, 8'd15, 4'hf, 1'b0, 32'h5A17_3C4D};
    tbl[8] = '{8'h80, 28'h001_2340, 8'd15, 4'he, 1'b0, 32'h0000_0001};
    tbl[9] = '{8'h80, 28'h000_0104, 8'd1, 4'h7, 1'b0, 32'h0000_0001};
    repeat (4) @(posedge bus_clock);
    #1;
    bus_reset = 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      cur     = i;
      n_words = int'(tbl[i].len) + 1;
      s       = tbl[i].seed;
      for (int k = 0; k < n_words; k++) begin
        s            = xorshift32(s);
        exp_words[k] = s;
        if (tbl[i].cmd == 8'h01 && !tbl[i].err) ref_mem[tbl[i].addr + 28'(4 * k)] = s;
      end
      seen = rx_frames;
      send_frame(tbl[i], n_words);
      if (tbl[i].cmd == 8'h01 || tbl[i].cmd == 8'h80) begin
        while (rx_frames == seen) @(posedge bus_clock);
        #1;
        check_response(tbl[i], n_words);
      end else begin
        repeat (20) @(posedge bus_clock);  // Quiet window
        #1;
        if (rx_bytes.size() != 0) begin
          $display("Unknown command 0x%h produced %0d response bytes", tbl[i].cmd,
                   rx_bytes.size());
          errors++;
          rx_bytes.delete();
          rx_lasts.delete();
        end
      end
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: bench/memreq_props.sv
`timescale 1ns/10ps
module memreq_props (
  input logic                   bus_clock,
  input logic                   bus_reset,
  input logic                   s_tready_o,
  input logic                   m_tvalid_o,
  input logic                   m_tready_i,
  input logic                   m_tlast_o,
  input logic [7:0]             m_tdata_o,
  input logic                   awvalid_o,
  input logic                   awready_i,
  input memreq_pkg::mem_addr_t  awaddr_o,
  input memreq_pkg::txn_id_t    awid_o,
  input memreq_pkg::burst_len_t awlen_o,
  input logic                   arvalid_o,
  input logic                   arready_i,
  input memreq_pkg::mem_addr_t  araddr_o,
  input memreq_pkg::txn_id_t    arid_o,
  input memreq_pkg::burst_len_t arlen_o,
  input logic                   wvalid_o,
  input logic                   bready_o,
  input logic                   rready_o
);

  // Valid holds with a stable payload until ready
  a_aw_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awid_o) &&
    $stable(awlen_o)) else $error("AW payload changed before awready");

  a_ar_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arid_o) &&
    $stable(arlen_o)) else $error("AR payload changed before arready");

  a_m_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) && $stable(m_tlast_o))
    else $error("Response byte changed before m_tready");

  a_one_request: assert property (@(posedge bus_clock) disable iff (bus_reset)
    !(awvalid_o && arvalid_o)) else $error("AW and AR valid together");

  a_reset_state: assert property (@(posedge bus_clock)
    bus_reset |=> !awvalid_o && !wvalid_o && !bready_o && !arvalid_o && !rready_o &&
    !m_tvalid_o && s_tready_o) else $error("Outputs not idle after reset");

endmodule

bind memreq_top memreq_props u_props (
  .bus_clock, .bus_reset, .s_tready_o,
  .m_tvalid_o, .m_tready_i, .m_tlast_o, .m_tdata_o,
  .awvalid_o, .awready_i, .awaddr_o, .awid_o, .awlen_o,
  .arvalid_o, .arready_i, .araddr_o, .arid_o, .arlen_o,
  .wvalid_o, .bready_o, .rready_o
);

// File: hdl/memreq_top.sv
`timescale 1ns/10ps
`include "memreq_params.svh"
module memreq_top (
  input  logic                            bus_clock,
  input  logic                            bus_reset,
  input  logic                            s_tvalid_i,
  output logic                            s_tready_o,
  input  logic                            s_tlast_i,
  input  logic [7:0]                      s_tdata_i,
  output logic                            m_tvalid_o,
  input  logic                            m_tready_i,
  output logic                            m_tlast_o,
  output logic [7:0]                      m_tdata_o,
  output logic                            awvalid_o,
  input  logic                            awready_i,
  output memreq_pkg::mem_addr_t           awaddr_o,
  output memreq_pkg::txn_id_t             awid_o,
  output memreq_pkg::burst_len_t          awlen_o,
  output logic [1:0]                      awburst_o,
  output logic                            wvalid_o,
  input  logic                            wready_i,
  output logic                            wlast_o,
  output logic [`MEMREQ_DATA_WIDTH/8-1:0] wstrb_o,
  output memreq_pkg::mem_word_t           wdata_o,
  input  logic                            bvalid_i,
  output logic                            bready_o,
  input  memreq_pkg::axi_resp_t           bresp_i,
  input  memreq_pkg::txn_id_t             bid_i,
  output logic                            arvalid_o,
  input  logic                            arready_i,
  output memreq_pkg::mem_addr_t           araddr_o,
  output memreq_pkg::txn_id_t             arid_o,
  output memreq_pkg::burst_len_t          arlen_o,
  output logic [1:0]                      arburst_o,
  input  logic                            rvalid_i,
  output logic                            rready_o,
  input  logic                            rlast_i,
  input  memreq_pkg::axi_resp_t           rresp_i,
  input  memreq_pkg::txn_id_t             rid_i,
  input  memreq_pkg::mem_word_t           rdata_i
);

  // Request fields shared by both ports
  logic wr_start, rd_start;
  memreq_pkg::mem_addr_t req_addr;
  memreq_pkg::burst_len_t req_len;
  memreq_pkg::txn_id_t req_id;

  logic word_valid, word_ready, word_last;
  memreq_pkg::mem_word_t word_data;

  logic wr_done, wr_ok;
  memreq_pkg::txn_id_t wr_id;

  logic rword_valid, rword_ready, rword_last, rword_ok;
  memreq_pkg::mem_word_t rword_data;
  memreq_pkg::txn_id_t rword_id;

  logic frame_done;

  cmd_parser u_parser (
    .bus_clock, .bus_reset,
    .s_tvalid_i, .s_tready_o, .s_tlast_i, .s_tdata_i,
    .wr_start_o(wr_start), .rd_start_o(rd_start),
    .req_addr_o(req_addr), .req_len_o(req_len), .req_id_o(req_id),
    .word_valid_o(word_valid), .word_ready_i(word_ready),
    .word_data_o(word_data), .word_last_o(word_last),
    .frame_done_i(frame_done)
  );

  axi_write_port u_write (
    .bus_clock, .bus_reset,
    .wr_start_i(wr_start), .req_addr_i(req_addr), .req_len_i(req_len), .req_id_i(req_id),
    .word_valid_i(word_valid), .word_ready_o(word_ready),
    .word_data_i(word_data), .word_last_i(word_last),
    .awvalid_o, .awready_i, .awaddr_o, .awid_o, .awlen_o, .awburst_o,
    .wvalid_o, .wready_i, .wlast_o, .wstrb_o, .wdata_o,
    .bvalid_i, .bready_o, .bresp_i, .bid_i,
    .wr_done_o(wr_done), .wr_ok_o(wr_ok), .wr_id_o(wr_id)
  );

  axi_read_port u_read (
    .bus_clock, .bus_reset,
    .rd_start_i(rd_start), .req_addr_i(req_addr), .req_len_i(req_len), .req_id_i(req_id),
    .arvalid_o, .arready_i, .araddr_o, .arid_o, .arlen_o, .arburst_o,
    .rvalid_i, .rready_o, .rlast_i, .rresp_i, .rid_i, .rdata_i,
    .rword_valid_o(rword_valid), .rword_ready_i(rword_ready),
    .rword_data_o(rword_data), .rword_last_o(rword_last),
    .rword_ok_o(rword_ok), .rword_id_o(rword_id)
  );

  resp_encoder u_encoder (
    .bus_clock, .bus_reset,
    .wr_done_i(wr_done), .wr_ok_i(wr_ok), .wr_id_i(wr_id),
    .rword_valid_i(rword_valid), .rword_ready_o(rword_ready),
    .rword_data_i(rword_data), .rword_last_i(rword_last),
    .rword_ok_i(rword_ok), .rword_id_i(rword_id),
    .m_tvalid_o, .m_tready_i, .m_tlast_o, .m_tdata_o,
    .frame_done_o(frame_done)
  );

endmodule

// File: hdl/resp_encoder.sv
`timescale 1ns/10ps
module resp_encoder (
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  wr_done_i,
  input  logic                  wr_ok_i,
  input  memreq_pkg::txn_id_t   wr_id_i,
  input  logic                  rword_valid_i,
  output logic                  rword_ready_o,
  input  memreq_pkg::mem_word_t rword_data_i,
  input  logic                  rword_last_i,
  input  logic                  rword_ok_i,
  input  memreq_pkg::txn_id_t   rword_id_i,
  output logic                  m_tvalid_o,
  input  logic                  m_tready_i,
  output logic                  m_tlast_o,
  output logic [7:0]            m_tdata_o,
  output logic                  frame_done_o
);

  memreq_pkg::enc_state_e state;
  memreq_pkg::cmd_e code_q;
  memreq_pkg::txn_id_t id_q;
  logic rd_q;  // Read response in progress
  logic [1:0] byte_idx;

  assign m_tvalid_o = (state == memreq_pkg::ES_CODE) || (state == memreq_pkg::ES_ID) ||
                      (state == memreq_pkg::ES_BYTES && rword_valid_i);
  assign m_tlast_o  = (state == memreq_pkg::ES_ID && !rd_q) ||
                      (state == memreq_pkg::ES_BYTES && byte_idx == 2'd3 && rword_last_i);
  // Word leaves the read port with its fourth byte
  assign rword_ready_o = (state == memreq_pkg::ES_BYTES) && m_tready_i && byte_idx == 2'd3;

  always_comb begin
    case (state)
      memreq_pkg::ES_CODE: m_tdata_o = code_q;
      memreq_pkg::ES_ID:   m_tdata_o = 8'(id_q);
      default:             m_tdata_o = rword_data_i[{byte_idx, 3'b000} +: 8];
    endcase
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state        <= memreq_pkg::ES_IDLE;
      frame_done_o <= 1'b0;
      byte_idx     <= 2'd0;
    end else begin
      frame_done_o <= 1'b0;
      case (state)
        memreq_pkg::ES_IDLE: if (wr_done_i || rword_valid_i) state <= memreq_pkg::ES_CODE;
        memreq_pkg::ES_CODE: if (m_tready_i) state <= memreq_pkg::ES_ID;
        memreq_pkg::ES_ID: if (m_tready_i) begin
          byte_idx     <= 2'd0;
          frame_done_o <= !rd_q;
          state        <= rd_q ? memreq_pkg::ES_BYTES : memreq_pkg::ES_IDLE;
        end
        memreq_pkg::ES_BYTES: if (m_tvalid_o && m_tready_i) begin
          byte_idx <= byte_idx + 2'd1;
          if (m_tlast_o) begin
            frame_done_o <= 1'b1;
            state        <= memreq_pkg::ES_IDLE;
          end
        end
        default: state <= memreq_pkg::ES_IDLE;
      endcase
    end
  end

  // Status code follows the first read beat only
  always_ff @(posedge bus_clock) begin
    if (state == memreq_pkg::ES_IDLE) begin
      if (wr_done_i) begin
        rd_q   <= 1'b0;
        code_q <= wr_ok_i ? memreq_pkg::CMD_WDONE : memreq_pkg::CMD_WFAIL;
        id_q   <= wr_id_i;
      end else if (rword_valid_i) begin
        rd_q   <= 1'b1;
        code_q <= rword_ok_i ? memreq_pkg::CMD_RDATA : memreq_pkg::CMD_RFAIL;
        id_q   <= rword_id_i;
      end
    end
  end

endmodule

// File: hdl/axi_read_port.sv
`timescale 1ns/10ps
`include "memreq_params.svh"
module axi_read_port (
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   rd_start_i,
  input  memreq_pkg::mem_addr_t  req_addr_i,
  input  memreq_pkg::burst_len_t req_len_i,
  input  memreq_pkg::txn_id_t    req_id_i,
  output logic                   arvalid_o,
  input  logic                   arready_i,
  output memreq_pkg::mem_addr_t  araddr_o,
  output memreq_pkg::txn_id_t    arid_o,
  output memreq_pkg::burst_len_t arlen_o,
  output logic [1:0]             arburst_o,
  input  logic                   rvalid_i,
  output logic                   rready_o,
  input  logic                   rlast_i,
  input  memreq_pkg::axi_resp_t  rresp_i,
  input  memreq_pkg::txn_id_t    rid_i,
  input  memreq_pkg::mem_word_t  rdata_i,
  output logic                   rword_valid_o,
  input  logic                   rword_ready_i,
  output memreq_pkg::mem_word_t  rword_data_o,
  output logic                   rword_last_o,
  output logic                   rword_ok_o,
  output memreq_pkg::txn_id_t    rword_id_o
);

  memreq_pkg::rd_state_e state;
  logic r_fire;

  assign arburst_o = `MEMREQ_BURST_INCR;

  // One-word holding register, so R stalls behind the encoder
  assign rready_o = (state == memreq_pkg::RS_DATA) && !rword_valid_o;
  assign r_fire   = rvalid_i && rready_o;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state     <= memreq_pkg::RS_IDLE;
      arvalid_o <= 1'b0;
    end else begin
      case (state)
        memreq_pkg::RS_IDLE: if (rd_start_i) begin
          arvalid_o <= 1'b1;
          state     <= memreq_pkg::RS_ADDR;
        end
        memreq_pkg::RS_ADDR: if (arready_i) begin
          arvalid_o <= 1'b0;
          state     <= memreq_pkg::RS_DATA;
        end
        memreq_pkg::RS_DATA: if (r_fire && rlast_i) state <= memreq_pkg::RS_IDLE;
        default: state <= memreq_pkg::RS_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      rword_valid_o <= 1'b0;
    end else if (rword_valid_o && rword_ready_i) begin
      rword_valid_o <= 1'b0;
    end else if (r_fire) begin
      rword_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (state == memreq_pkg::RS_IDLE && rd_start_i) begin
      araddr_o <= req_addr_i;
      arid_o   <= req_id_i;
      arlen_o  <= req_len_i;
    end
    if (r_fire) begin
      rword_data_o <= rdata_i;
      rword_last_o <= rlast_i;
      rword_ok_o   <= rresp_i == `MEMREQ_RESP_OKAY;
      rword_id_o   <= rid_i;
    end
  end

endmodule

// File: hdl/axi_write_port.sv
`timescale 1ns/10ps
`include "memreq_params.svh"
module axi_write_port (
  input  logic                                bus_clock,
  input  logic                                bus_reset,
  input  logic                                wr_start_i,
  input  memreq_pkg::mem_addr_t               req_addr_i,
  input  memreq_pkg::burst_len_t              req_len_i,
  input  memreq_pkg::txn_id_t                 req_id_i,
  input  logic                                word_valid_i,
  output logic                                word_ready_o,
  input  memreq_pkg::mem_word_t               word_data_i,
  input  logic                                word_last_i,
  output logic                                awvalid_o,
  input  logic                                awready_i,
  output memreq_pkg::mem_addr_t               awaddr_o,
  output memreq_pkg::txn_id_t                 awid_o,
  output memreq_pkg::burst_len_t              awlen_o,
  output logic [1:0]                          awburst_o,
  output logic                                wvalid_o,
  input  logic                                wready_i,
  output logic                                wlast_o,
  output logic [`MEMREQ_DATA_WIDTH/8-1:0]     wstrb_o,
  output memreq_pkg::mem_word_t               wdata_o,
  input  logic                                bvalid_i,
  output logic                                bready_o,
  input  memreq_pkg::axi_resp_t               bresp_i,
  input  memreq_pkg::txn_id_t                 bid_i,
  output logic                                wr_done_o,
  output logic                                wr_ok_o,
  output memreq_pkg::txn_id_t                 wr_id_o
);

  memreq_pkg::wr_state_e state;

  assign awburst_o = `MEMREQ_BURST_INCR;
  assign wstrb_o   = '1;  // Whole words only

  // Parser words go straight onto W
  assign wvalid_o     = (state == memreq_pkg::WS_DATA) && word_valid_i;
  assign word_ready_o = (state == memreq_pkg::WS_DATA) && wready_i;
  assign wdata_o      = word_data_i;
  assign wlast_o      = word_last_i;
  assign bready_o     = state == memreq_pkg::WS_RESP;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state     <= memreq_pkg::WS_IDLE;
      awvalid_o <= 1'b0;
      wr_done_o <= 1'b0;
    end else begin
      wr_done_o <= 1'b0;
      case (state)
        memreq_pkg::WS_IDLE: if (wr_start_i) begin
          awvalid_o <= 1'b1;
          state     <= memreq_pkg::WS_ADDR;
        end
        memreq_pkg::WS_ADDR: if (awready_i) begin
          awvalid_o <= 1'b0;
          state     <= memreq_pkg::WS_DATA;
        end
        memreq_pkg::WS_DATA: if (wvalid_o && wready_i && wlast_o) state <= memreq_pkg::WS_RESP;
        memreq_pkg::WS_RESP: if (bvalid_i) begin
          wr_done_o <= 1'b1;
          state     <= memreq_pkg::WS_IDLE;
        end
        default: state <= memreq_pkg::WS_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (state == memreq_pkg::WS_IDLE && wr_start_i) begin
      awaddr_o <= req_addr_i;
      awid_o   <= req_id_i;
      awlen_o  <= req_len_i;
    end
    if (bvalid_i && bready_o) begin
      wr_ok_o <= bresp_i == `MEMREQ_RESP_OKAY;
      wr_id_o <= bid_i;
    end
  end

endmodule

// File: hdl/cmd_parser.sv
`timescale 1ns/10ps
module cmd_parser (
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   s_tvalid_i,
  output logic                   s_tready_o,
  input  logic                   s_tlast_i,
  input  logic [7:0]             s_tdata_i,
  output logic                   wr_start_o,
  output logic                   rd_start_o,
  output memreq_pkg::mem_addr_t  req_addr_o,
  output memreq_pkg::burst_len_t req_len_o,
  output memreq_pkg::txn_id_t    req_id_o,
  output logic                   word_valid_o,
  input  logic                   word_ready_i,
  output memreq_pkg::mem_word_t  word_data_o,
  output logic                   word_last_o,
  input  logic                   frame_done_i
);

  memreq_pkg::parse_state_e state;
  memreq_pkg::cmd_e cmd_q;
  logic [1:0] byte_idx;  // Byte lane within the word being packed
  logic s_fire;

  // Stall input while a word waits for W, and until the response is out
  assign s_tready_o = (state != memreq_pkg::PS_WAIT) && !word_valid_o;
  assign s_fire = s_tvalid_i && s_tready_o;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state        <= memreq_pkg::PS_IDLE;
      wr_start_o   <= 1'b0;
      rd_start_o   <= 1'b0;
      word_valid_o <= 1'b0;
      byte_idx     <= 2'd0;
    end else begin
      wr_start_o <= 1'b0;
      rd_start_o <= 1'b0;
      case (state)
        memreq_pkg::PS_IDLE: if (s_fire) begin
          if (s_tdata_i == memreq_pkg::CMD_STORE || s_tdata_i == memreq_pkg::CMD_FETCH) begin
            state <= memreq_pkg::PS_SIZE;
          end else if (!s_tlast_i) begin
            state <= memreq_pkg::PS_SKIP;  // Unknown command, drop the frame
          end
        end
        memreq_pkg::PS_SIZE: if (s_fire) state <= memreq_pkg::PS_ADR0;
        memreq_pkg::PS_ADR0: if (s_fire) state <= memreq_pkg::PS_ADR1;
        memreq_pkg::PS_ADR1: if (s_fire) state <= memreq_pkg::PS_ADR2;
        memreq_pkg::PS_ADR2: if (s_fire) state <= memreq_pkg::PS_IDAD;
        memreq_pkg::PS_IDAD: if (s_fire) begin
          byte_idx <= 2'd0;
          if (cmd_q == memreq_pkg::CMD_STORE) begin
            wr_start_o <= 1'b1;
            state      <= memreq_pkg::PS_DATA;
          end else begin
            rd_start_o <= 1'b1;
            state      <= memreq_pkg::PS_WAIT;
          end
        end
        memreq_pkg::PS_DATA: begin
          if (word_valid_o && word_ready_i) begin
            word_valid_o <= 1'b0;
            if (word_last_o) state <= memreq_pkg::PS_WAIT;
          end else if (s_fire) begin
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3 || s_tlast_i) word_valid_o <= 1'b1;
          end
        end
        memreq_pkg::PS_SKIP: if (s_fire && s_tlast_i) state <= memreq_pkg::PS_IDLE;
        memreq_pkg::PS_WAIT: if (frame_done_i) state <= memreq_pkg::PS_IDLE;
        default: state <= memreq_pkg::PS_IDLE;
      endcase
    end
  end

  // Header fields and the packed store word
  always_ff @(posedge bus_clock) begin
    if (s_fire) begin
      case (state)
        memreq_pkg::PS_IDLE: cmd_q <= memreq_pkg::cmd_e'(s_tdata_i);
        memreq_pkg::PS_SIZE: req_len_o <= s_tdata_i;
        memreq_pkg::PS_ADR0: req_addr_o[7:0] <= s_tdata_i;
        memreq_pkg::PS_ADR1: req_addr_o[15:8] <= s_tdata_i;
        memreq_pkg::PS_ADR2: req_addr_o[23:16] <= s_tdata_i;
        memreq_pkg::PS_IDAD: {req_id_o, req_addr_o[27:24]} <= s_tdata_i;
        memreq_pkg::PS_DATA: begin
          word_data_o[{byte_idx, 3'b000} +: 8] <= s_tdata_i;  // Little-endian
          word_last_o <= s_tlast_i;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/memreq_pkg.sv
package memreq_pkg;

  `include "memreq_params.svh"

  typedef logic [`MEMREQ_ADDR_WIDTH-1:0] mem_addr_t;  // Byte address
  typedef logic [`MEMREQ_DATA_WIDTH-1:0] mem_word_t;  // One data beat
  typedef logic [`MEMREQ_ID_WIDTH-1:0] txn_id_t;
  typedef logic [7:0] burst_len_t;  // Beats minus one
  typedef logic [1:0] axi_resp_t;

  // Command bytes in, status bytes out
  typedef enum logic [7:0] {
    CMD_NOP   = 8'h00,
    CMD_STORE = 8'h01,
    CMD_WDONE = 8'h02,
    CMD_WFAIL = 8'h03,
    CMD_FETCH = 8'h80,
    CMD_RDATA = 8'h81,
    CMD_RFAIL = 8'h82
  } cmd_e;

  typedef enum logic [3:0] {
    PS_IDLE, PS_SIZE, PS_ADR0, PS_ADR1, PS_ADR2, PS_IDAD, PS_DATA, PS_SKIP, PS_WAIT
  } parse_state_e;

  typedef enum logic [1:0] {WS_IDLE, WS_ADDR, WS_DATA, WS_RESP} wr_state_e;
  typedef enum logic [1:0] {RS_IDLE, RS_ADDR, RS_DATA} rd_state_e;
  typedef enum logic [1:0] {ES_IDLE, ES_CODE, ES_ID, ES_BYTES} enc_state_e;

endpackage

// File: hdl/memreq_params.svh
`ifndef MEMREQ_PARAMS_SVH
`define MEMREQ_PARAMS_SVH

// Memory-side bus widths
`define MEMREQ_ADDR_WIDTH 28
`define MEMREQ_DATA_WIDTH 32
`define MEMREQ_ID_WIDTH 4

// AXI encodings
`define MEMREQ_BURST_INCR 2'b01
`define MEMREQ_RESP_OKAY 2'b00

`endif
